// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ice_app
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: include/ice_app_defines.svh
`ifndef ICE_APP_DEFINES_SVH
`define ICE_APP_DEFINES_SVH

// ==============================
// Command message
// ==============================
// Bits that follow the start bit
`define ICE_MSG_LEN     16
`define ICE_TYPE_LEN    4
`define ICE_ARG_LEN     12

// ==============================
// Data path
// ==============================
`define ICE_WORD_W      16   // Response and image word
`define ICE_LED_W       4

// ==============================
// Readout buffer
// ==============================
// Depth must stay a power of two
`define ICE_FIFO_DEPTH  16
`define ICE_FIFO_AW     4

`endif

// File: logic/cmd_engine.sv
`default_nettype none

`include "ice_app_defines.svh"

module cmd_engine (
    input  logic                   img_clk,
    input  logic                   spi_rst_,
    input  logic                   msg_valid,
    input  ice_app_pkg::msg_type_e msg_type,
    input  ice_app_pkg::msg_arg_t  msg_arg,
    output logic                   listen,
    input  ice_app_pkg::fill_t     fifo_fill,
    input  logic                   rd_valid,
    input  ice_app_pkg::word_t     rd_data,
    output logic                   rd_en,
    output logic                   word_valid,
    output ice_app_pkg::word_t     word_data,
    input  logic                   word_ready,
    output ice_app_pkg::led_t      led
);
    import ice_app_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,     // Word offered to the serializer
        ST_READOUT,  // Waiting on buffer and line
        ST_DRAIN     // Last word still on the line
    } state_e;

    state_e     state;
    logic [7:0] words_left;  // Readout words not yet fetched
    logic       fetch;
    logic       decode;

    // Receiver stays deaf from the decode cycle until the line is free
    assign listen = (state == ST_IDLE) && !msg_valid;
    assign decode = (state == ST_IDLE) && msg_valid;

    // Pop only when the serializer can take the word right away
    assign fetch = (state == ST_READOUT) && rd_valid && word_ready;
    assign rd_en = fetch;

    // ==============================
    // Command FSM
    // ==============================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state      <= ST_IDLE;
            word_valid <= 1'b0;
            words_left <= '0;
            led        <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (msg_valid) begin
                        case (msg_type)
                            MSG_READY: begin
                                word_valid <= 1'b1;
                                words_left <= '0;  // Single word reply
                                state      <= ST_SEND;
                            end
                            MSG_LED_SET: begin
                                led <= msg_arg[`ICE_LED_W-1:0];
                            end
                            MSG_READOUT: begin
                                words_left <= msg_arg[7:0];
                                if (msg_arg[7:0] != 8'd0) begin
                                    state <= ST_READOUT;
                                end
                            end
                            default: begin
                                // Nop and unknown codes
                            end
                        endcase
                    end
                end

                ST_SEND: begin
                    if (word_ready) begin
                        word_valid <= 1'b0;
                        state      <= (words_left == 8'd0) ? ST_DRAIN : ST_READOUT;
                    end
                end

                ST_READOUT: begin
                    if (fetch) begin
                        word_valid <= 1'b1;
                        words_left <= words_left - 8'd1;
                        state      <= ST_SEND;
                    end
                end

                ST_DRAIN: begin
                    if (word_ready) begin
                        state <= ST_IDLE;  // Final bit has left
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Outgoing word
    // ==============================
    always_ff @(posedge img_clk) begin
        if (decode && (msg_type == MSG_READY)) begin
            // Echo byte on top, fill count below
            word_data <= {msg_arg[7:0], 8'(fifo_fill)};
        end else if (fetch) begin
            word_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/ice_app_pkg.sv
`default_nettype none

`include "ice_app_defines.svh"

package ice_app_pkg;

    // ==============================
    // Message fields
    // ==============================
    // Type codes as sent by the host
    typedef enum logic [`ICE_TYPE_LEN-1:0] {
        MSG_NOP     = 4'd0,
        MSG_READY   = 4'd1,  // Echo plus buffer fill
        MSG_LED_SET = 4'd2,
        MSG_READOUT = 4'd3   // Stream buffered words
    } msg_type_e;

    typedef logic [`ICE_ARG_LEN-1:0] msg_arg_t;

    // ==============================
    // Data path
    // ==============================
    typedef logic [`ICE_WORD_W-1:0] word_t;

    typedef logic [`ICE_LED_W-1:0] led_t;

    // One bit wider than the address so a full buffer can be told apart
    typedef logic [`ICE_FIFO_AW:0] fill_t;

endpackage

`default_nettype wire

// File: logic/ice_app_top.sv
`default_nettype none

module ice_app_top (
    input  logic               img_clk,
    input  logic               spi_rst_,
    input  logic               spi_data_in,
    output logic               spi_data_out,
    output logic               spi_data_oe,
    input  logic               pix_valid,
    input  ice_app_pkg::word_t pix_data,
    output logic               pix_ready,
    output ice_app_pkg::led_t  led
);
    import ice_app_pkg::*;

    // Receiver to engine
    logic      listen;
    logic      msg_valid;
    msg_type_e msg_type;
    msg_arg_t  msg_arg;

    // Engine to serializer
    logic      word_valid;
    word_t     word_data;
    logic      word_ready;

    // Buffer read side
    logic      rd_en;
    logic      rd_valid;
    word_t     rd_data;
    fill_t     fifo_fill;

    // ==============================
    // Command path
    // ==============================
    msg_receiver i_msg_receiver (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .spi_data_in (spi_data_in),
        .listen      (listen),
        .msg_valid   (msg_valid),
        .msg_type    (msg_type),
        .msg_arg     (msg_arg)
    );

    cmd_engine i_cmd_engine (
        .img_clk    (img_clk),
        .spi_rst_   (spi_rst_),
        .msg_valid  (msg_valid),
        .msg_type   (msg_type),
        .msg_arg    (msg_arg),
        .listen     (listen),
        .fifo_fill  (fifo_fill),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_ready (word_ready),
        .led        (led)
    );

    // ==============================
    // Line and buffer
    // ==============================
    word_serializer i_word_serializer (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .word_ready   (word_ready),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe)
    );

    readout_fifo i_readout_fifo (
        .img_clk   (img_clk),
        .spi_rst_  (spi_rst_),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .rd_en     (rd_en),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .fill      (fifo_fill)
    );

endmodule

`default_nettype wire

// File: logic/msg_receiver.sv
`default_nettype none

`include "ice_app_defines.svh"

module msg_receiver (
    input  logic                   img_clk,
    input  logic                   spi_rst_,
    input  logic                   spi_data_in,
    input  logic                   listen,
    output logic                   msg_valid,
    output ice_app_pkg::msg_type_e msg_type,
    output ice_app_pkg::msg_arg_t  msg_arg
);
    import ice_app_pkg::*;

    localparam int CNT_W = $clog2(`ICE_MSG_LEN + 1);

    logic [CNT_W-1:0]        bit_cnt;  // Bits still expected
    logic [`ICE_MSG_LEN-1:0] msg_sr;
    logic                    busy;

    assign busy = (bit_cnt != '0);

    // Start bit detect and bit count
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == CNT_W'(1)) begin
                    msg_valid <= 1'b1;  // Last bit lands this edge
                end
            end else if (listen && spi_data_in) begin
                bit_cnt <= CNT_W'(`ICE_MSG_LEN);
            end
        end
    end

    // MSB first, so new bits enter at the bottom
    always_ff @(posedge img_clk) begin
        if (busy) begin
            msg_sr <= {msg_sr[`ICE_MSG_LEN-2:0], spi_data_in};
        end
    end

    // Fields held stable until the next start bit
    assign msg_type = msg_type_e'(msg_sr[`ICE_MSG_LEN-1 -: `ICE_TYPE_LEN]);
    assign msg_arg  = msg_sr[`ICE_ARG_LEN-1:0];

endmodule

`default_nettype wire

// File: logic/readout_fifo.sv
`default_nettype none

`include "ice_app_defines.svh"

module readout_fifo (
    input  logic               img_clk,
    input  logic               spi_rst_,
    input  logic               pix_valid,
    input  ice_app_pkg::word_t pix_data,
    output logic               pix_ready,
    input  logic               rd_en,
    output logic               rd_valid,
    output ice_app_pkg::word_t rd_data,
    output ice_app_pkg::fill_t fill
);
    import ice_app_pkg::*;

    localparam int AW = `ICE_FIFO_AW;

    word_t       mem [`ICE_FIFO_DEPTH];
    logic [AW:0] wr_ptr;  // Top bit is the wrap flag
    logic [AW:0] rd_ptr;
    logic        push;
    logic        pop;

    // ==============================
    // Status
    // ==============================
    assign fill      = fill_t'(wr_ptr - rd_ptr);
    assign pix_ready = (fill != fill_t'(`ICE_FIFO_DEPTH));  // Back-pressure when full
    assign rd_valid  = (fill != '0);

    assign push = pix_valid && pix_ready;
    assign pop  = rd_en && rd_valid;

    // Head word visible without a read strobe
    assign rd_data = mem[rd_ptr[AW-1:0]];

    // ==============================
    // Pointers
    // ==============================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge img_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= pix_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/word_serializer.sv
`default_nettype none

`include "ice_app_defines.svh"

module word_serializer (
    input  logic               img_clk,
    input  logic               spi_rst_,
    input  logic               word_valid,
    input  ice_app_pkg::word_t word_data,
    output logic               word_ready,
    output logic               spi_data_out,
    output logic               spi_data_oe
);
    import ice_app_pkg::*;

    localparam int CNT_W = $clog2(`ICE_WORD_W + 1);

    logic [CNT_W-1:0] bit_cnt;  // Bits left on the line
    word_t            shift_q;
    logic             load;

    assign word_ready = (bit_cnt == '0);
    assign load       = word_valid && word_ready;

    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= CNT_W'(`ICE_WORD_W);
        end else if (!word_ready) begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    // MSB leaves first
    always_ff @(posedge img_clk) begin
        if (load) begin
            shift_q <= word_data;
        end else begin
            shift_q <= {shift_q[`ICE_WORD_W-2:0], 1'b0};
        end
    end

    // Line held low while not driving
    assign spi_data_oe  = !word_ready;
    assign spi_data_out = spi_data_oe && shift_q[`ICE_WORD_W-1];

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
logic/ice_app_pkg.sv
logic/msg_receiver.sv
logic/cmd_engine.sv
logic/word_serializer.sv
logic/readout_fifo.sv
logic/ice_app_top.sv
testbench/ice_app_sva.sv
testbench/tb_ice_app.sv

// File: testbench/ice_app_sva.sv
`default_nettype none

`include "ice_app_defines.svh"

module ice_app_sva (
    input logic img_clk,
    input logic spi_rst_,
    input logic spi_data_oe,
    input logic pix_valid,
    input logic pix_ready,
    input logic rd_en
);
    import ice_app_pkg::*;

    logic [4:0] oe_run;    // Consecutive high cycles so far
    fill_t      occupied;  // Buffer level rebuilt from the two handshakes
    int         fail_cnt = 0;

    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            oe_run <= '0;
        end else if (spi_data_oe) begin
            oe_run <= oe_run + 5'd1;
        end else begin
            oe_run <= '0;
        end
    end

    // Push side counts up, pop side counts down
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            occupied <= '0;
        end else begin
            occupied <= occupied + fill_t'(pix_valid && pix_ready) - fill_t'(rd_en);
        end
    end

    // ==============================
    // Line and buffer protocol
    // ==============================
    oe_full_word: assert property (@(posedge img_clk) disable iff (!spi_rst_)
        $fell(spi_data_oe) |-> (oe_run == 5'd16))
        else begin
            fail_cnt++;
            $error("spi_data_oe dropped before 16 bits");
        end

    oe_no_overrun: assert property (@(posedge img_clk) disable iff (!spi_rst_)
        spi_data_oe |-> (oe_run < 5'd16))
        else begin
            fail_cnt++;
            $error("spi_data_oe held longer than 16 bits");
        end

    full_no_ready: assert property (@(posedge img_clk) disable iff (!spi_rst_)
        (occupied == fill_t'(`ICE_FIFO_DEPTH)) |-> !pix_ready)
        else begin
            fail_cnt++;
            $error("pix_ready high with a full FIFO");
        end

    pop_needs_data: assert property (@(posedge img_clk) disable iff (!spi_rst_)
        rd_en |-> (occupied != '0))
        else begin
            fail_cnt++;
            $error("rd_en raised on an empty FIFO");
        end

endmodule

bind ice_app_top ice_app_sva i_ice_app_sva (
    .img_clk     (img_clk),
    .spi_rst_    (spi_rst_),
    .spi_data_oe (spi_data_oe),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .rd_en       (rd_en)
);

`default_nettype wire

// File: testbench/tb_ice_app.sv
`default_nettype none

`include "ice_app_defines.svh"

module tb_ice_app;
    import ice_app_pkg::*;

    localparam int CLK_HALF   = 4;
    localparam int WAIT_LIMIT = 500;  // Cycles per wait

    logic  img_clk;
    logic  spi_rst_;
    logic  spi_data_in;
    logic  spi_data_out;
    logic  spi_data_oe;
    logic  pix_valid;
    word_t pix_data;
    logic  pix_ready;
    led_t  led;

    // Scoreboard state
    word_t model_q[$];  // Words the FIFO should hold, head first
    word_t exp_q[$];    // Pending Ready replies
    word_t got_q[$];
    word_t line_sr;
    int    line_bits     = 0;
    int    readout_left  = 0;
    int    words_checked = 0;
    int    pushed_cnt    = 0;
    int    oe_cycles     = 0;
    int    cyc           = 0;
    int    last_bit_cyc  = 0;
    int    start_cyc     = 0;

    ice_app_top i_ice_app_top (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .pix_ready    (pix_ready),
        .led          (led)
    );

    initial begin
        img_clk = 1'b0;
        forever begin
            #CLK_HALF img_clk = ~img_clk;
        end
    end

    always @(posedge img_clk) begin
        cyc <= cyc + 1;
    end

    // ==============================
    // Checks
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("Fail at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // Expected reply for a message, readout words come from the model head
    function automatic word_t ref_word(input msg_type_e t, input msg_arg_t arg);
        case (t)
            MSG_READY:   ref_word = {arg[7:0], 8'(model_q.size())};
            MSG_READOUT: ref_word = model_q[0];
            default:     ref_word = '0;
        endcase
    endfunction

    // ==============================
    // Monitors
    // ==============================
    always @(posedge img_clk) begin
        if (spi_data_oe) begin
            if (line_bits == 0) begin
                start_cyc = cyc;  // First bit of a word
            end
            line_sr = {line_sr[`ICE_WORD_W-2:0], spi_data_out};
            line_bits++;
            oe_cycles++;
            if (line_bits == `ICE_WORD_W) begin
                got_q.push_back(line_sr);
                line_bits = 0;
            end
        end else if (line_bits != 0) begin
            abort_run($sformatf("Response word cut short after %0d bits", line_bits));
        end
    end

    always @(posedge img_clk) begin
        if (spi_rst_ && pix_valid && pix_ready) begin
            model_q.push_back(pix_data);
            pushed_cnt++;
        end
    end

    always @(negedge img_clk) begin : compare_words
        word_t got;
        while (got_q.size() != 0) begin
            got = got_q.pop_front();
            if (exp_q.size() != 0) begin
                check_word(got, exp_q.pop_front(), "Ready reply");
            end else if (readout_left > 0 && model_q.size() != 0) begin
                check_word(got, ref_word(MSG_READOUT, '0), "Readout word");
                model_q.delete(0);
                readout_left--;
            end else begin
                abort_run("A response word arrived when none was expected");
            end
            words_checked++;
        end
    end

    // A failed protocol assertion ends the run here too
    always @(negedge img_clk) begin
        if (i_ice_app_top.i_ice_app_sva.fail_cnt != 0) begin
            abort_run("A protocol assertion in the bound checker failed");
        end
    end

    // ==============================
    // Host and pixel drivers
    // ==============================
    task automatic idle(input int n);
        repeat (n) @(negedge img_clk);
    endtask

    task automatic send_msg(input logic [`ICE_TYPE_LEN-1:0] code, input msg_arg_t arg);
        logic [`ICE_MSG_LEN-1:0] bits;
        bits = {code, arg};
        @(negedge img_clk);
        spi_data_in = 1'b1;  // Start bit
        for (int i = `ICE_MSG_LEN - 1; i >= 0; i--) begin
            @(negedge img_clk);
            spi_data_in = bits[i];
        end
        last_bit_cyc = cyc;
        @(negedge img_clk);
        spi_data_in = 1'b0;
    endtask

    task automatic wait_words(input int target);
        int waited;
        waited = 0;
        while (words_checked < target) begin
            @(posedge img_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("Timeout waiting for response word %0d", target));
            end
        end
    endtask

    task automatic push_pixels(input int n, input int max_gap);
        int gap;
        int start;
        int waited;
        for (int i = 0; i < n; i++) begin
            gap = $urandom_range(0, max_gap);
            repeat (gap) @(negedge img_clk);
            start     = pushed_cnt;
            pix_valid = 1'b1;
            pix_data  = word_t'($urandom);
            waited    = 0;
            while (pushed_cnt == start) begin
                @(negedge img_clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("Timeout waiting for the FIFO to accept a pixel word");
                end
            end
            pix_valid = 1'b0;
        end
    endtask

    task automatic ready_roundtrip();
        msg_arg_t arg;
        int       base;
        arg  = msg_arg_t'($urandom);
        base = words_checked;
        exp_q.push_back(ref_word(MSG_READY, arg));
        send_msg(MSG_READY, arg);
        wait_words(base + 1);
        check_count(start_cyc - last_bit_cyc, 3, "Ready first bit latency");
        idle(4);
    endtask

    task automatic start_readout(input int n);
        readout_left += n;
        send_msg(MSG_READOUT, {4'($urandom), 8'(n)});
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin : main_seq
        msg_arg_t arg;
        led_t     led_before;
        int       base;
        int       oe_before;
        spi_rst_    = 1'b0;
        spi_data_in = 1'b0;
        pix_valid   = 1'b0;
        pix_data    = '0;
        void'($urandom(32'haf6bb420));
        repeat (4) @(negedge img_clk);
        spi_rst_ = 1'b1;
        @(negedge img_clk);
        check_led(led, '0, "led after reset");
        check_bit(spi_data_oe, 1'b0, "spi_data_oe after reset");
        check_bit(pix_ready, 1'b1, "pix_ready after reset");

        repeat (6) begin
            arg = msg_arg_t'($urandom);
            send_msg(MSG_LED_SET, arg);
            idle(3);
            check_led(led, arg[`ICE_LED_W-1:0], "led after LEDSet");
        end
        check_count(oe_cycles, 0, "oe cycles during LEDSet");

        repeat (3) ready_roundtrip();  // Empty FIFO

        // Buffered words, drained in two parts
        push_pixels(6, 2);
        ready_roundtrip();
        base = words_checked;
        start_readout(4);
        wait_words(base + 4);
        idle(4);
        ready_roundtrip();
        base = words_checked;
        start_readout(2);
        wait_words(base + 2);
        idle(4);

        // Readout waits on an empty FIFO
        base = words_checked;
        start_readout(4);
        push_pixels(4, 5);
        wait_words(base + 4);
        idle(4);

        // Fill the FIFO with nothing reading
        base = pushed_cnt;
        push_pixels(`ICE_FIFO_DEPTH, 0);
        pix_data  = word_t'($urandom);
        pix_valid = 1'b1;
        idle(3);
        check_bit(pix_ready, 1'b0, "pix_ready with full FIFO");
        check_count(pushed_cnt - base, `ICE_FIFO_DEPTH, "words accepted by full FIFO");
        pix_valid = 1'b0;
        ready_roundtrip();
        base = words_checked;
        start_readout(`ICE_FIFO_DEPTH);
        wait_words(base + `ICE_FIFO_DEPTH);
        idle(4);
        check_bit(pix_ready, 1'b1, "pix_ready after drain");

        // Nop and unknown codes leave everything alone
        push_pixels(3, 1);
        led_before = led;
        oe_before  = oe_cycles;
        send_msg(MSG_NOP, msg_arg_t'($urandom));
        idle(4);
        repeat (4) begin
            send_msg(4'($urandom_range(4, 15)), msg_arg_t'($urandom));
            idle(4);
        end
        check_count(oe_cycles, oe_before, "oe cycles after Nop and unknown types");
        check_led(led, led_before, "led after Nop and unknown types");
        ready_roundtrip();
        base = words_checked;
        start_readout(3);
        wait_words(base + 3);
        idle(4);

        if (got_q.size() != 0 || exp_q.size() != 0 || readout_left != 0 ||
            model_q.size() != 0) begin
            abort_run("The run ended with unmatched words left in the scoreboard");
        end else if (i_ice_app_top.i_ice_app_sva.fail_cnt != 0) begin
            abort_run("A protocol assertion in the bound checker failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
